// File: usbCtrlEp.f
+incdir+src
src/usbSpecPkg.sv
src/ctrlEpPkg.sv
src/ctrlStageTracker.sv
src/descriptorRom.sv
src/descriptorStreamer.sv
src/deviceAddress.sv
src/usbCtrlEp.sv
test/tbClock.sv
test/usbCtrlEpTb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it, exit status is the result
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --timescale 1ns/1ps \
    -f usbCtrlEp.f --top-module usbCtrlEpTb &&
  ./obj_dir/VusbCtrlEpTb ||
  { echo "build or simulation did not complete cleanly"; exit 1; }

// File: test/usbCtrlEpTb.sv
`timescale 1ns/1ps
`include "usbCtrlEp_macros.svh"

module usbCtrlEpTb;

  localparam int CLK_PERIOD_NS = 4;
  localparam int NB_W          = $clog2(`MAX_PKT) + 1;

  // one control transfer and what it should produce
  typedef struct packed {
    ctrlEpPkg::setupPkt_t setup;
    logic [1:0]           expStall;  // {er0, et0}
    logic                 expDevice; // device descriptor, else config set
    logic [6:0]           expTotal;  // bytes carried by the data stage
    logic [3:0]           expPkts;   // in packets incl zero-length ones
    logic [3:0]           minHold;   // extra back-pressure cycles
    logic [6:0]           expAddr;   // address once the row is done
  } testRow_t;

  // descriptor bytes in wire order, usb 2.0 chapter 9 layout
  localparam logic [7:0] DEVICE_REF [0:17] = '{
    8'h12, 8'h01, 8'h00, 8'h02, 8'h00, 8'h00, 8'h00, 8'h08, // bcdUSB 2.0, ep0 size 8
    8'h37, 8'h13, 8'h55, 8'hf0, 8'h00, 8'h00,               // vid 1337, pid f055
    8'h00, 8'h00, 8'h00, 8'h01                              // no strings, one config
  };
  localparam logic [7:0] CONFIG_REF [0:31] = '{
    8'h09, 8'h02, 8'h20, 8'h00, 8'h01, 8'h01, 8'h00, 8'hc0, 8'h32, // config, 32 total
    8'h09, 8'h04, 8'h00, 8'h00, 8'h02, 8'hff, 8'h00, 8'h00, 8'h00, // vendor interface
    8'h07, 8'h05, 8'h01, 8'h02, 8'h08, 8'h00, 8'h00,               // bulk out ep1
    8'h07, 8'h05, 8'h81, 8'h02, 8'h08, 8'h00, 8'h00                // bulk in ep1
  };

  logic                  clk;
  logic                  reset;
  ctrlEpPkg::txnFlags_t  txnType;
  logic                  er0Valid;
  ctrlEpPkg::epPayload_t er0Pkt;
  logic                  er0Ready;
  logic                  et0Ready;
  logic                  et0Valid;
  ctrlEpPkg::epPayload_t et0Pkt;
  logic                  er0Stall;
  logic                  et0Stall;
  logic [6:0]            devAddr;

  testRow_t    rows[$];
  string       rowNames[$];
  string       curTest;
  logic [6:0]  curAddr;    // address the DUT should show right now
  logic [15:0] lfsrState;
  logic        tableReady;

  tbClock #(.PERIOD(CLK_PERIOD_NS)) clkGen (.o_clk(clk));

  usbCtrlEp uut (
    .i_clk      (clk),
    .i_reset    (reset),
    .i_txnType  (txnType),
    .i_er0Valid (er0Valid),
    .i_er0Pkt   (er0Pkt),
    .o_er0Ready (er0Ready),
    .i_et0Ready (et0Ready),
    .o_et0Valid (et0Valid),
    .o_et0Pkt   (et0Pkt),
    .o_er0Stall (er0Stall),
    .o_et0Stall (et0Stall),
    .o_devAddr  (devAddr)
  );

  task automatic endWithFailure();
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkPayload(input string what, input ctrlEpPkg::epPayload_t exp,
                              input ctrlEpPkg::epPayload_t act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %h len %0d actual %h len %0d",
               curTest, what, exp.data, exp.nBytes, act.data, act.nBytes);
      endWithFailure();
    end
  endtask

  task automatic checkAddr(input string what, input logic [6:0] exp, input logic [6:0] act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %h actual %h", curTest, what, exp, act);
      endWithFailure();
    end
  endtask

  task automatic checkStall(input string what, input logic [1:0] exp, input logic [1:0] act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %b actual %b", curTest, what, exp, act);
      endWithFailure();
    end
  endtask

  task automatic checkBit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %b actual %b", curTest, what, exp, act);
      endWithFailure();
    end
  endtask

  // galois form, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic takeBits(input int n, output int value);
    value = 0;
    repeat (n) begin
      value     = (value << 1) | int'(lfsrState[0]);
      lfsrState = lfsrStep(lfsrState); // one step per bit
    end
  endtask

  function automatic logic [7:0] refByte(input logic isDevice, input int idx);
    if (isDevice) return (idx < 18) ? DEVICE_REF[5'(idx)] : 8'h00;
    return (idx < 32) ? CONFIG_REF[5'(idx)] : 8'h00;
  endfunction

  // packet k carries min(MAX_PKT, bytes left), bytes past the length are zero
  function automatic ctrlEpPkg::epPayload_t expectedPkt(input testRow_t row, input int k);
    ctrlEpPkg::epPayload_t p;
    int                    left;
    int                    n;
    p    = '0;
    left = int'(row.expTotal) - k * `MAX_PKT;
    n    = (left > `MAX_PKT) ? `MAX_PKT : left;
    p.nBytes = NB_W'(n);
    for (int b = 0; b < n; b++) begin
      p.data[8*b +: 8] = refByte(row.expDevice, k * `MAX_PKT + b);
    end
    return p;
  endfunction

  // bytes past nBytes never reach the wire
  function automatic ctrlEpPkg::epPayload_t maskPayload(input ctrlEpPkg::epPayload_t p);
    ctrlEpPkg::epPayload_t m;
    m = p;
    for (int b = 0; b < `MAX_PKT; b++) begin
      if (b >= int'(p.nBytes)) m.data[8*b +: 8] = 8'h00;
    end
    return m;
  endfunction

  // fields in wire order, bmRequestType first
  function automatic ctrlEpPkg::setupPkt_t makeSetup(input logic [7:0] bmRequestType,
      input usbSpecPkg::bRequest_e bRequest, input logic [15:0] wValue,
      input logic [15:0] wLength);
    return ctrlEpPkg::setupPkt_t'({wLength, 16'h0000, wValue, bRequest, bmRequestType});
  endfunction

  function automatic ctrlEpPkg::setupPkt_t getDesc(input usbSpecPkg::descType_e dt,
                                                   input logic [15:0] wLength);
    return makeSetup(8'h80, usbSpecPkg::GET_DESCRIPTOR, {dt, 8'h00}, wLength);
  endfunction

  task automatic addRow(input string name, input ctrlEpPkg::setupPkt_t s, input logic [1:0] stall,
                        input logic isDev, input int total, input int pkts, input int hold,
                        input logic [6:0] addr);
    rows.push_back({s, stall, isDev, 7'(total), 4'(pkts), 4'(hold), addr});
    rowNames.push_back(name);
  endtask

  task automatic buildTable();
    addRow("devDesc64", getDesc(usbSpecPkg::DEVICE, 16'd64), 2'b00, 1'b1, 18, 3, 0, 7'h00);
    addRow("cfgDesc9", getDesc(usbSpecPkg::CONFIGURATION, 16'd9), 2'b00, 1'b0, 9, 2, 0, 7'h00);
    addRow("cfgDesc32Hold", getDesc(usbSpecPkg::CONFIGURATION, 16'd32),
           2'b00, 1'b0, 32, 5, 4, 7'h00); // ends with a zero-length packet
    addRow("stringStall", getDesc(usbSpecPkg::STRING, 16'd64), 2'b01, 1'b0, 0, 0, 0, 7'h00);
    addRow("writeStall", makeSetup(8'h00, usbSpecPkg::SET_DESCRIPTOR, 16'h0100, 16'd18),
           2'b10, 1'b0, 0, 1, 0, 7'h00);
    addRow("setAddress", makeSetup(8'h00, usbSpecPkg::SET_ADDRESS, 16'h002A, 16'd0),
           2'b00, 1'b0, 0, 1, 2, 7'h2A);
    addRow("devDescAfterAddr", getDesc(usbSpecPkg::DEVICE, 16'd18), 2'b00, 1'b1, 18, 3, 0, 7'h2A);
    addRow("devDescShort8", getDesc(usbSpecPkg::DEVICE, 16'd8), 2'b00, 1'b1, 8, 2, 1, 7'h2A);
  endtask

  task automatic stepDrive();
    @(posedge clk);
    #1; // inputs change 1 ns after the edge
  endtask

  task automatic waitValid();
    int waited;
    waited = 0;
    while (!et0Valid) begin
      if (waited == 16) begin
        $display("%s: DUT never offered the expected IN packet", curTest);
        endWithFailure();
      end
      stepDrive();
      #1;
      waited++;
    end
  endtask

  task automatic sendSetup(input testRow_t row);
    stepDrive();
    txnType.setup = 1'b1;
    er0Valid      = 1'b1;
    er0Pkt.data   = row.setup;
    er0Pkt.nBytes = NB_W'(8);
    #1;
    checkBit("setup ready", 1'b1, er0Ready);
    stepDrive(); // accepted at this edge
    txnType  = '0;
    er0Valid = 1'b0;
    er0Pkt   = '0;
    #1;
    checkStall("stalls after setup", row.expStall, {er0Stall, et0Stall});
    checkAddr("address after setup", curAddr, devAddr);
  endtask

  task automatic serveIn(input testRow_t row, input int k);
    ctrlEpPkg::epPayload_t exp;
    int                    hold;
    exp = expectedPkt(row, k);
    takeBits(2, hold);
    hold = hold + int'(row.minHold);
    waitValid();
    repeat (hold) begin // host not ready yet
      checkPayload("held packet", exp, maskPayload(et0Pkt));
      checkAddr("address while held", curAddr, devAddr);
      stepDrive();
      #1;
      checkBit("valid under back-pressure", 1'b1, et0Valid);
    end
    stepDrive();
    txnType.in = 1'b1;
    et0Ready   = 1'b1; // ack this cycle
    #1;
    checkPayload("acked packet", exp, maskPayload(et0Pkt));
    checkAddr("address before ack", curAddr, devAddr);
    stepDrive();
    txnType  = '0;
    et0Ready = 1'b0;
    #1;
  endtask

  task automatic sendStatusOut();
    stepDrive();
    txnType.out = 1'b1;
    er0Valid    = 1'b1;
    er0Pkt      = '0; // zero-length status
    #1;
    checkBit("status out ready", 1'b1, er0Ready);
    stepDrive();
    txnType  = '0;
    er0Valid = 1'b0;
    #1;
    checkBit("valid after status out", 1'b0, et0Valid);
    checkBit("ready after status out", 1'b0, er0Ready);
  endtask

  task automatic runRow(input int idx);
    testRow_t row;
    logic     readXfer;
    row      = rows[idx];
    curTest  = rowNames[idx];
    readXfer = row.setup.dirIn && (row.setup.wLength != 16'd0) && !row.expStall[0];
    sendSetup(row);
    for (int k = 0; k < int'(row.expPkts); k++) serveIn(row, k);
    checkBit("valid after data", 1'b0, et0Valid);
    checkAddr("address after data", row.expAddr, devAddr);
    if (readXfer) sendStatusOut();
    if (row.expStall != 2'b00) begin
      repeat (2) begin // stall stays until the next setup
        stepDrive();
        #1;
        checkStall("stall held", row.expStall, {er0Stall, et0Stall});
        checkBit("valid while stalled", 1'b0, et0Valid);
      end
    end
    curAddr = row.expAddr;
  endtask

  initial begin
    reset      = 1'b1;
    txnType    = '0;
    er0Valid   = 1'b0;
    er0Pkt     = '0;
    et0Ready   = 1'b0;
    lfsrState  = 16'd22214;
    curAddr    = 7'd0;
    tableReady = 1'b0;
    curTest    = "afterReset";
    buildTable();
    tableReady = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    #1;
    checkBit("valid", 1'b0, et0Valid);
    checkStall("stalls", 2'b00, {er0Stall, et0Stall});
    checkAddr("address", 7'd0, devAddr);
    stepDrive();
    txnType.out = 1'b1; // idle stage acks setups only
    #1;
    checkBit("ready on out", 1'b0, er0Ready);
    foreach (rows[i]) runRow(i);
    $display("TEST PASSED");
    $finish;
  end

  // watchdog, 200 cycles per row
  initial begin
    int limitNs;
    wait (tableReady);
    limitNs = rows.size() * 200 * CLK_PERIOD_NS;
    #(limitNs);
    $display("simulation hung, no result after %0d ns", limitNs);
    endWithFailure();
  end

endmodule

// File: test/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
  parameter int PERIOD = 4 // ns
) (
  output logic o_clk
);

  initial o_clk = 1'b0; // first rising edge at PERIOD/2

  always #(PERIOD / 2) o_clk = ~o_clk; // 50% duty

endmodule

// File: src/usbCtrlEp.sv
`timescale 1ns/1ps

module usbCtrlEp (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  ctrlEpPkg::txnFlags_t  i_txnType,  // token of current transaction
  input  logic                  i_er0Valid,
  input  ctrlEpPkg::epPayload_t i_er0Pkt,
  output logic                  o_er0Ready,
  input  logic                  i_et0Ready, // high for one cycle on ack or stall
  output logic                  o_et0Valid,
  output ctrlEpPkg::epPayload_t o_et0Pkt,
  output logic                  o_er0Stall,
  output logic                  o_et0Stall,
  output logic [6:0]            o_devAddr
);

  ctrlEpPkg::ctrlStage_e stage;
  ctrlEpPkg::ctrlReq_t   req;
  logic                  tfrBegin;
  logic                  statusIn;
  logic                  et0ZeroLen;

  assign et0ZeroLen = (o_et0Pkt.nBytes == '0); // status packets are empty

  ctrlStageTracker tracker (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_txnType    (i_txnType),
    .i_er0Valid   (i_er0Valid),
    .i_er0Pkt     (i_er0Pkt),
    .i_et0Ready   (i_et0Ready),
    .i_et0Valid   (o_et0Valid),
    .i_et0ZeroLen (et0ZeroLen),
    .o_er0Ready   (o_er0Ready),
    .o_stage      (stage),
    .o_req        (req),
    .o_er0Stall   (o_er0Stall),
    .o_et0Stall   (o_et0Stall),
    .o_begin      (tfrBegin),
    .o_statusIn   (statusIn)
  );

  descriptorStreamer streamer (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_stage    (stage),
    .i_req      (req),
    .i_begin    (tfrBegin),
    .i_et0Ready (i_et0Ready),
    .o_et0Valid (o_et0Valid),
    .o_et0Pkt   (o_et0Pkt)
  );

  deviceAddress addrReg (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_begin    (tfrBegin),
    .i_req      (req),
    .i_statusIn (statusIn),
    .o_devAddr  (o_devAddr)
  );

endmodule

// File: src/deviceAddress.sv
`timescale 1ns/1ps

module deviceAddress (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic                i_begin,    // new setup accepted
  input  ctrlEpPkg::ctrlReq_t i_req,
  input  logic                i_statusIn, // zero-length status in acked
  output logic [6:0]          o_devAddr
);

  logic       armed;   // status of the current transfer not yet seen
  logic       applied; // sticky once an address took effect
  logic [6:0] addrQ;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      armed   <= 1'b0;
      applied <= 1'b0;
    end else if (i_begin) begin
      armed <= 1'b1;
    end else if (i_statusIn && armed) begin
      armed <= 1'b0;
      if (i_req.isSetAddress) applied <= 1'b1;
    end
  end

  // new address only after the status stage completes
  always_ff @(posedge i_clk) begin
    if (i_statusIn && armed && i_req.isSetAddress) begin
      addrQ <= i_req.setup.descIndex[6:0]; // wValue bits 6:0
    end
  end

  assign o_devAddr = applied ? addrQ : 7'd0; // default address until set

endmodule

// File: src/descriptorStreamer.sv
`timescale 1ns/1ps
`include "usbCtrlEp_macros.svh"

module descriptorStreamer (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  ctrlEpPkg::ctrlStage_e i_stage,
  input  ctrlEpPkg::ctrlReq_t   i_req,
  input  logic                  i_begin,    // setup accepted
  input  logic                  i_et0Ready, // host acked
  output logic                  o_et0Valid,
  output ctrlEpPkg::epPayload_t o_et0Pkt
);

  localparam int NBYTES_W = $clog2(`MAX_PKT) + 1;

  logic [2:0]            pktCnt;    // packets acked in this transfer
  logic [6:0]            sentBytes;
  logic [6:0]            leftBytes;
  logic                  moreData;
  logic [8*`MAX_PKT-1:0] window;

  descriptorRom descRom (
    .i_selDevice (i_req.selDevice),
    .i_pktIndex  (pktCnt),
    .o_window    (window)
  );

  assign sentBytes = 7'(pktCnt) * 7'(`MAX_PKT);
  // equal counts too, so an exact multiple ends with a zero-length packet
  assign moreData  = (sentBytes <= i_req.nBytesToSend);
  assign leftBytes = i_req.nBytesToSend - sentBytes; // only meaningful with moreData

  always_comb begin
    o_et0Pkt.data = window;
    case (i_stage)
      ctrlEpPkg::STAGE_READ: begin
        o_et0Valid      = moreData;
        o_et0Pkt.nBytes = (leftBytes >= 7'(`MAX_PKT)) ?
                          NBYTES_W'(`MAX_PKT) : leftBytes[NBYTES_W-1:0];
      end
      ctrlEpPkg::STAGE_NODATA, ctrlEpPkg::STAGE_WRITE: begin
        o_et0Valid      = 1'b1; // zero-length status packet
        o_et0Pkt.nBytes = '0;
      end
      default: begin
        o_et0Valid      = 1'b0;
        o_et0Pkt.nBytes = '0;
      end
    endcase
  end

  // advances only on ack, so data holds under back-pressure
  always_ff @(posedge i_clk) begin
    if (i_reset || i_begin) begin
      pktCnt <= '0;
    end else if (o_et0Valid && i_et0Ready) begin
      pktCnt <= pktCnt + 3'd1;
    end
  end

  pktSizeLimit: assert property (@(posedge i_clk) disable iff (i_reset)
    o_et0Valid |-> (o_et0Pkt.nBytes <= NBYTES_W'(`MAX_PKT)))
    else $error("in packet longer than MAX_PKT");

endmodule

// File: src/descriptorRom.sv
`timescale 1ns/1ps
`include "usbCtrlEp_macros.svh"

module descriptorRom (
  input  logic                  i_selDevice, // device, else config set
  input  logic [2:0]            i_pktIndex,
  output logic [8*`MAX_PKT-1:0] o_window
);

  localparam int WIN_W = 8 * `MAX_PKT;
  localparam int ROM_W = 8 * WIN_W; // one window per pktIndex value

  // usbserial device descriptor, last byte first
  localparam logic [8*`DEVICE_LEN-1:0] DEVICE_DESC = {
    8'd1,                          // bNumConfigurations
    8'd0,                          // iSerialNumber
    8'd0,                          // iProduct
    8'd0,                          // iManufacturer
    16'h0000,                      // bcdDevice
    `PRODUCT_ID,                   // idProduct
    `VENDOR_ID,                    // idVendor
    8'(`MAX_PKT),                  // bMaxPacketSize0
    8'd0,                          // bDeviceProtocol
    8'd0,                          // bDeviceSubClass
    usbSpecPkg::BASECLASS_UNKNOWN, // bDeviceClass, see interface
    16'h0200,                      // bcdUSB 2.0
    usbSpecPkg::DEVICE,            // bDescriptorType
    8'(`DEVICE_LEN)                // bLength
  };

  // config, vendor interface, bulk out ep1, bulk in ep1
  localparam logic [8*`CONFIG_LEN-1:0] CONFIG_DESC = {
    8'd0,                          // bInterval, unused for bulk
    16'(`MAX_PKT),                 // wMaxPacketSize
    usbSpecPkg::ENDPTYPE_BULK,     // bmAttributes
    8'h81,                         // bEndpointAddress, ep1 in
    usbSpecPkg::ENDPOINT,
    8'd7,
    8'd0,                          // bInterval
    16'(`MAX_PKT),                 // wMaxPacketSize
    usbSpecPkg::ENDPTYPE_BULK,
    8'h01,                         // bEndpointAddress, ep1 out
    usbSpecPkg::ENDPOINT,
    8'd7,
    8'd0,                          // iInterface
    8'd0,                          // bInterfaceProtocol
    8'd0,                          // bInterfaceSubClass
    usbSpecPkg::BASECLASS_VENDOR,  // bInterfaceClass, driver matches vid:pid
    8'd2,                          // bNumEndpoints
    8'd0,                          // bAlternateSetting
    8'd0,                          // bInterfaceNumber
    usbSpecPkg::INTERFACE,
    8'd9,
    8'd50,                         // bMaxPower 100mA
    8'hc0,                         // bmAttributes, self and bus powered
    8'd0,                          // iConfiguration
    8'd1,                          // bConfigurationValue
    8'd1,                          // bNumInterfaces
    16'(`CONFIG_LEN),              // wTotalLength
    usbSpecPkg::CONFIGURATION,
    8'd9
  };

  // zero padded so windows past the end read as zero
  localparam logic [ROM_W-1:0] DEVICE_IMAGE = {{(ROM_W - 8*`DEVICE_LEN){1'b0}}, DEVICE_DESC};
  localparam logic [ROM_W-1:0] CONFIG_IMAGE = {{(ROM_W - 8*`CONFIG_LEN){1'b0}}, CONFIG_DESC};

  logic [ROM_W-1:0] image;

  assign image    = i_selDevice ? DEVICE_IMAGE : CONFIG_IMAGE;
  assign o_window = image[i_pktIndex*WIN_W +: WIN_W]; // byte pktIndex*MAX_PKT in bits 7:0

endmodule

// File: src/ctrlStageTracker.sv
`timescale 1ns/1ps
`include "usbCtrlEp_macros.svh"

module ctrlStageTracker (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  ctrlEpPkg::txnFlags_t  i_txnType,
  input  logic                  i_er0Valid,
  input  ctrlEpPkg::epPayload_t i_er0Pkt,
  input  logic                  i_et0Ready, // ack or stall seen
  input  logic                  i_et0Valid,
  input  logic                  i_et0ZeroLen,
  output logic                  o_er0Ready,
  output ctrlEpPkg::ctrlStage_e o_stage,
  output ctrlEpPkg::ctrlReq_t   o_req,
  output logic                  o_er0Stall,
  output logic                  o_et0Stall,
  output logic                  o_begin,    // setup accepted this cycle
  output logic                  o_statusIn  // no-data status in accepted
);

  ctrlEpPkg::setupPkt_t  setupIn;
  ctrlEpPkg::ctrlStage_e reqStage;
  logic                  outAccepted;
  logic                  zeroInSent;
  logic                  isRead;
  logic                  isWrite;
  logic                  isGetDesc;
  logic                  descKnown;
  logic                  supported;
  logic                  fullDesc;
  logic [6:0]            descLen;
  logic [6:0]            reqDescLen; // length of the latched descriptor

  assign setupIn = ctrlEpPkg::setupPkt_t'(i_er0Pkt.data); // raw bytes as setup fields

  // ack setups always, and the zero-length status out of a read
  assign o_er0Ready  = i_txnType.setup || (o_stage == ctrlEpPkg::STAGE_READ);
  assign o_begin     = i_txnType.setup && i_er0Valid && o_er0Ready;
  assign outAccepted = i_txnType.out && i_er0Valid && o_er0Ready;
  assign zeroInSent  = i_txnType.in && i_et0Valid && i_et0Ready && i_et0ZeroLen;
  assign o_statusIn  = zeroInSent && (o_stage == ctrlEpPkg::STAGE_NODATA);

  assign isRead    = (setupIn.wLength != '0) && setupIn.dirIn;
  assign isWrite   = (setupIn.wLength != '0) && !setupIn.dirIn;
  assign isGetDesc = (setupIn.bRequest == usbSpecPkg::GET_DESCRIPTOR);
  assign descKnown = (setupIn.descType == usbSpecPkg::DEVICE) ||
                     (setupIn.descType == usbSpecPkg::CONFIGURATION);
  assign supported = (setupIn.bRequest == usbSpecPkg::SET_ADDRESS) || (isGetDesc && descKnown);

  assign descLen = (setupIn.descType == usbSpecPkg::DEVICE) ? 7'(`DEVICE_LEN) : 7'(`CONFIG_LEN);
  // whole descriptor fits in the full 16-bit wLength
  assign fullDesc = ({9'b0, descLen} <= setupIn.wLength);

  assign reqDescLen = o_req.selDevice ? 7'(`DEVICE_LEN) : 7'(`CONFIG_LEN);

  always_comb begin
    if (setupIn.wLength == '0) begin
      reqStage = ctrlEpPkg::STAGE_NODATA; // status in only
    end else if (setupIn.dirIn) begin
      // a stalled read never enters its data stage
      reqStage = supported ? ctrlEpPkg::STAGE_READ : ctrlEpPkg::STAGE_IDLE;
    end else begin
      reqStage = ctrlEpPkg::STAGE_WRITE; // stalled below, data never taken
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_stage    <= ctrlEpPkg::STAGE_IDLE;
      o_et0Stall <= 1'b0;
      o_er0Stall <= 1'b0;
      o_req      <= '0;
    end else if (o_begin) begin // any setup restarts the transfer
      o_stage                <= reqStage;
      o_et0Stall             <= isRead && !supported;  // held until next setup
      o_er0Stall             <= isWrite && !supported;
      o_req.setup            <= setupIn;
      o_req.isSetAddress     <= (setupIn.bRequest == usbSpecPkg::SET_ADDRESS);
      o_req.selDevice        <= (setupIn.descType == usbSpecPkg::DEVICE);
      o_req.nBytesToSend     <= fullDesc ? descLen : setupIn.wLength[6:0];
    end else begin
      case (o_stage)
        ctrlEpPkg::STAGE_READ: begin
          if (outAccepted) o_stage <= ctrlEpPkg::STAGE_IDLE; // status out acked
        end
        ctrlEpPkg::STAGE_NODATA, ctrlEpPkg::STAGE_WRITE: begin
          if (zeroInSent) o_stage <= ctrlEpPkg::STAGE_IDLE; // status in acked
        end
        default: o_stage <= o_stage;
      endcase
    end
  end

  stallExclusive: assert property (@(posedge i_clk) disable iff (i_reset)
    !(o_er0Stall && o_et0Stall))
    else $error("both endpoint 0 stalls raised");

  // short read length is wLength itself and never truncated
  shortLenFits: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_stage == ctrlEpPkg::STAGE_READ && o_req.nBytesToSend < reqDescLen)
      |-> (o_req.setup.wLength == 16'(o_req.nBytesToSend)))
    else $error("short read length does not match wLength");

endmodule

// File: src/ctrlEpPkg.sv
`include "usbCtrlEp_macros.svh"

package ctrlEpPkg;

  // 8-byte setup packet, first field is msb so byte 0 lands in bits 7:0
  typedef struct packed {
    logic [15:0]           wLength;   // bytes 7:6
    logic [15:0]           wIndex;    // bytes 5:4
    usbSpecPkg::descType_e descType;  // wValue high byte
    logic [7:0]            descIndex; // wValue low byte, also the new address
    usbSpecPkg::bRequest_e bRequest;  // byte 1
    logic                  dirIn;     // bmRequestType.7, device to host
    logic [1:0]            reqType;   // standard, class, vendor
    logic [4:0]            recipient; // device, interface, endpoint
  } setupPkt_t;

  // one endpoint packet and its length
  typedef struct packed {
    logic [8*`MAX_PKT-1:0]      data;
    logic [$clog2(`MAX_PKT):0]  nBytes;
  } epPayload_t;

  // token type of the current transaction, from the host-side engine
  typedef struct packed {
    logic setup;
    logic out;
    logic in;
  } txnFlags_t;

  // control transfer stage
  typedef enum logic [1:0] {
    STAGE_IDLE   = 2'd0,
    STAGE_NODATA = 2'd1, // setup, status in
    STAGE_READ   = 2'd2, // setup, data in, status out
    STAGE_WRITE  = 2'd3  // setup, data out, status in
  } ctrlStage_e;

  // latched and decoded request
  typedef struct packed {
    setupPkt_t  setup;
    logic       isSetAddress;
    logic       selDevice;    // device descriptor, else config set
    logic [6:0] nBytesToSend; // min of descriptor length and wLength
  } ctrlReq_t;

endpackage

// File: src/usbSpecPkg.sv
package usbSpecPkg;

  // standard bRequest codes, USB 2.0 table 9-4
  typedef enum logic [7:0] {
    GET_STATUS        = 8'd0,
    CLEAR_FEATURE     = 8'd1,
    SET_FEATURE       = 8'd3,
    SET_ADDRESS       = 8'd5,
    GET_DESCRIPTOR    = 8'd6,
    SET_DESCRIPTOR    = 8'd7,
    GET_CONFIGURATION = 8'd8,
    SET_CONFIGURATION = 8'd9
  } bRequest_e;

  // bDescriptorType values, table 9-5
  typedef enum logic [7:0] {
    DEVICE        = 8'd1,
    CONFIGURATION = 8'd2,
    STRING        = 8'd3, // never served here
    INTERFACE     = 8'd4,
    ENDPOINT      = 8'd5
  } descType_e;

  // class codes
  localparam logic [7:0] BASECLASS_UNKNOWN = 8'h00; // class defined per interface
  localparam logic [7:0] BASECLASS_VENDOR  = 8'hff; // vendor specific

  // bmAttributes transfer type
  localparam logic [7:0] ENDPTYPE_BULK = 8'h02;

endpackage

// File: src/usbCtrlEp_macros.svh
`ifndef USBCTRLEP_MACROS_SVH
`define USBCTRLEP_MACROS_SVH

// endpoint 0 packet size in bytes, also bMaxPacketSize0
`define MAX_PKT 8

// usbserial binds to this exact pair
`define VENDOR_ID 16'h1337
`define PRODUCT_ID 16'hf055

// device descriptor bLength
`define DEVICE_LEN 18

// config + interface + two endpoints, 9+9+7+7 bytes
`define CONFIG_LEN 32

`endif
